// File: node_settings.svh
`ifndef NODE_SETTINGS_SVH
`define NODE_SETTINGS_SVH

`define NODE_INPUTS 75

// activations, weights and the output share one width
`define ACT_WIDTH 8
`define PRODUCT_WIDTH 16
`define SUM_WIDTH 23

`define FRAC_BITS 6 // sum to output shift
`define NODE_BIAS 512
`define OUT_MAX 127

// weight k pairs with activation k
`define NODE_WEIGHTS '{ \
	 8'sd19, \
	-8'sd2, \
	 8'sd9, \
	 8'sd18, \
	-8'sd24, \
	 8'sd5, \
	-8'sd3, \
	 8'sd7, \
	-8'sd11, \
	 8'sd10, \
	 8'sd0, \
	-8'sd11, \
	 8'sd3, \
	-8'sd20, \
	-8'sd31, \
	-8'sd31, \
	-8'sd26, \
	-8'sd7, \
	 8'sd9, \
	 8'sd15, \
	 8'sd31, \
	 8'sd7, \
	 8'sd14, \
	 8'sd25, \
	 8'sd28, \
	 8'sd22, \
	 8'sd10, \
	-8'sd6, \
	 8'sd1, \
	 8'sd4, \
	-8'sd3, \
	 8'sd5, \
	 8'sd2, \
	-8'sd13, \
	-8'sd17, \
	 8'sd9, \
	 8'sd1, \
	 8'sd5, \
	 8'sd4, \
	 8'sd6, \
	 8'sd3, \
	 8'sd5, \
	 8'sd4, \
	-8'sd8, \
	-8'sd4, \
	-8'sd6, \
	 8'sd8, \
	 8'sd7, \
	 8'sd11, \
	 8'sd13, \
	 8'sd12, \
	-8'sd6, \
	 8'sd2, \
	-8'sd4, \
	-8'sd13, \
	 8'sd3, \
	-8'sd18, \
	 8'sd6, \
	-8'sd7, \
	-8'sd2, \
	-8'sd4, \
	-8'sd31, \
	-8'sd19, \
	-8'sd31, \
	-8'sd31, \
	-8'sd12, \
	 8'sd7, \
	 8'sd1, \
	-8'sd15, \
	 8'sd14, \
	-8'sd3, \
	 8'sd10, \
	-8'sd18, \
	 8'sd5, \
	-8'sd12 \
}

`endif

// File: node_pkg.sv
`default_nettype none

`include "node_settings.svh"

package node_pkg;

	// one signed activation lane
	typedef logic signed [`ACT_WIDTH-1:0] activation_t;

	// full product of activation and weight
	typedef logic signed [`PRODUCT_WIDTH-1:0] product_t;

	// wide enough for 75 products plus the bias
	typedef logic signed [`SUM_WIDTH-1:0] nodeSum_t;

	// whole input vector, act[k] goes with weight k
	typedef struct packed
	{
		activation_t [`NODE_INPUTS-1:0] act;
	} activationVec_t;

endpackage

`default_nettype wire

// File: nodeInputCapture.sv
`timescale 1ns/1ps
`default_nettype none

`include "node_settings.svh"

// decode stage
// holds the incoming vector for one cycle so the multipliers see stable operands
module nodeInputCapture
(
	input logic clk,
	input logic reset,
	input node_pkg::activationVec_t inputs,
	output node_pkg::activationVec_t captured
);

	import node_pkg::*;

	activationVec_t captureReg;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			captureReg <= '0;
		end
		else
		begin
			captureReg <= inputs; // new vector every cycle
		end
	end

	assign captured = captureReg;

	// pipeline starts from an all-zero vector
	assert property (@(posedge clk) reset |=> (captured == '0))
		else $error("captured vector not cleared after reset");

endmodule

`default_nettype wire

// File: weightedSum.sv
`timescale 1ns/1ps
`default_nettype none

`include "node_settings.svh"

// execute stage
// one multiplier per lane, then a single adder tree with the bias folded in
module weightedSum
(
	input logic clk,
	input logic reset,
	input node_pkg::activationVec_t captured,
	output node_pkg::nodeSum_t nodeSum
);

	import node_pkg::*;

	localparam activation_t WEIGHTS [0:`NODE_INPUTS-1] = `NODE_WEIGHTS;

	// bias at the sum width
	localparam nodeSum_t BIAS = `NODE_BIAS;

	product_t products [`NODE_INPUTS];
	nodeSum_t extended [`NODE_INPUTS];
	nodeSum_t sumNext;

	genvar i;

	generate
		for (i = 0; i < `NODE_INPUTS; i++)
		begin : genLane
			// signed 8x8, full 16 bit result
			assign products[i] = activation_t'(captured.act[i]) * WEIGHTS[i];

			// replicate the product sign up to the sum width
			assign extended[i] = {
				{(`SUM_WIDTH - `PRODUCT_WIDTH){products[i][`PRODUCT_WIDTH-1]}},
				products[i]
			};
		end
	endgenerate

	// cannot overflow, 75 * 128 * 128 + bias stays well inside 23 bits
	always_comb
	begin
		sumNext = BIAS;
		for (int k = 0; k < `NODE_INPUTS; k++)
		begin
			sumNext = sumNext + extended[k];
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			nodeSum <= '0;
		end
		else
		begin
			nodeSum <= sumNext;
		end
	end

endmodule

`default_nettype wire

// File: reluQuantize.sv
`timescale 1ns/1ps
`default_nettype none

`include "node_settings.svh"

// result stage
// ReLU, clamp and round-half-up from the wide sum down to one output byte
module reluQuantize
(
	input logic clk,
	input logic reset,
	input node_pkg::nodeSum_t nodeSum,
	output logic [`ACT_WIDTH-1:0] nodeOut
);

	localparam int TOP_BIT = `FRAC_BITS + `ACT_WIDTH - 1; // bit 13

	logic sumNegative;
	logic overRange;
	logic roundBit;
	logic [`ACT_WIDTH-1:0] truncated;
	logic [`ACT_WIDTH-1:0] rounded;
	logic [`ACT_WIDTH-1:0] outNext;

	assign sumNegative = nodeSum[`SUM_WIDTH-1];

	// anything at bit 13 or above is out of range
	assign overRange = |nodeSum[`SUM_WIDTH-2:TOP_BIT];

	assign truncated = nodeSum[TOP_BIT:`FRAC_BITS];
	assign roundBit = nodeSum[`FRAC_BITS-1]; // half lsb

	// may carry to 128, bit 13 being clear caps it there
	assign rounded = truncated + {{(`ACT_WIDTH-1){1'b0}}, roundBit};

	always_comb
	begin
		if (sumNegative)
		begin
			outNext = '0;
		end
		else if (overRange)
		begin
			outNext = `OUT_MAX;
		end
		else
		begin
			outNext = rounded;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			nodeOut <= '0;
		end
		else
		begin
			nodeOut <= outNext;
		end
	end

	// only the rounding carry may pass the clamp value
	assert property (@(posedge clk) disable iff (reset) nodeOut <= (`OUT_MAX + 1))
		else $error("nodeOut above 128: %0d", nodeOut);

	// a negative sum is zero on the next output
	assert property (@(posedge clk) (nodeSum < 0) |=> (nodeOut == '0))
		else $error("negative sum did not give a zero output");

endmodule

`default_nettype wire

// File: neuronNode.sv
`timescale 1ns/1ps
`default_nettype none

`include "node_settings.svh"

// single fully connected neuron
// capture, weighted sum, activation: three register stages, one vector per cycle
module neuronNode
(
	input logic clk,
	input logic reset,
	input node_pkg::activationVec_t inputs,
	output logic [`ACT_WIDTH-1:0] nodeOut
);

	import node_pkg::*;

	activationVec_t captured;
	nodeSum_t nodeSum;

	nodeInputCapture u_capture
	(
		.clk(clk),
		.reset(reset),
		.inputs(inputs),
		.captured(captured)
	);

	weightedSum u_sum
	(
		.clk(clk),
		.reset(reset),
		.captured(captured),
		.nodeSum(nodeSum)
	);

	// output lands three edges after the inputs are sampled
	reluQuantize u_relu
	(
		.clk(clk),
		.reset(reset),
		.nodeSum(nodeSum),
		.nodeOut(nodeOut)
	);

endmodule

`default_nettype wire

// File: neuronChecker.sv
`timescale 1ns/1ps
`default_nettype none

`include "node_settings.svh"

// delays the expected values by the pipeline depth and compares them with nodeOut
module neuronChecker
#(
	parameter int PIPE_DEPTH = 3
)
(
	input logic clk,
	input logic reset,
	input logic [`ACT_WIDTH-1:0] nodeOut,
	input logic expValid,
	input logic [`ACT_WIDTH-1:0] expValue,
	input int testId,
	output int checkedCount,
	output int errorCount
);

	typedef struct packed
	{
		logic valid;
		logic [`ACT_WIDTH-1:0] value;
		logic signed [31:0] id; // -1 marks an idle slot
	} expEntry_t;

	expEntry_t delayLine [PIPE_DEPTH];
	logic resetClocked = 1'b0;
	int checks = 0;
	int errors = 0;

	assign checkedCount = checks;
	assign errorCount = errors;

	always @(posedge clk)
	begin
		if (reset)
		begin
			resetClocked <= 1'b1;
			for (int i = 0; i < PIPE_DEPTH; i++)
			begin
				delayLine[i] <= '0;
			end
		end
		else
		begin
			delayLine[0] <= {expValid, expValue, testId};
			for (int i = 1; i < PIPE_DEPTH; i++)
			begin
				delayLine[i] <= delayLine[i-1];
			end
		end
	end

	// nodeOut settles after the rising edge, so compare on the falling one
	always @(negedge clk)
	begin : compareOutput
		expEntry_t head;
		head = delayLine[PIPE_DEPTH-1];
		if (reset)
		begin
			if (resetClocked && (nodeOut !== '0))
			begin
				errors++;
				$display("Mismatch at %0t: nodeOut is %0d during reset, expected 0",
					$time, nodeOut);
			end
		end
		else if (head.valid)
		begin
			checks++;
			if (nodeOut !== head.value)
			begin
				errors++;
				$display("Mismatch at %0t: slot %0d (-1 is idle) expected %0d, got %0d",
					$time, head.id, head.value, nodeOut);
			end
			else if (head.id < 0)
			begin
				$display("idle slot ok, nodeOut %0d", nodeOut);
			end
			else
			begin
				$display("test %0d ok, nodeOut %0d", head.id, nodeOut);
			end
		end
	end

endmodule

`default_nettype wire

// File: neuronNode_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "node_settings.svh"

module neuronNode_tb;

	import node_pkg::*;

	localparam int CLK_PERIOD = 40;
	localparam int PIPE_DEPTH = 3;
	localparam int RESET_CYCLES = 5;
	localparam int DRIVE_DELAY = 2;
	localparam int MAX_TESTS = 32;
	localparam int ROW_LEN = `NODE_INPUTS + 1; // activations, then expected output
	localparam string TEST_FILE = "node_tests.dat";

	logic clk = 1'b0;
	logic reset;
	activationVec_t inputs;
	logic [`ACT_WIDTH-1:0] nodeOut;
	logic expValid;
	logic [`ACT_WIDTH-1:0] expValue;
	int testId;
	int checkedCount;
	int errorCount;

	logic [8:0] testMem [0:MAX_TESTS*ROW_LEN-1]; // bit 8 set means not loaded
	int schedule [$]; // test index per slot, -1 for an idle vector
	int numTests;
	int numIdle;
	int seed = 32'h2e7c;
	logic loadFailed;
	logic scheduleReady = 1'b0;

	always #(CLK_PERIOD / 2) clk = ~clk;

	neuronNode u_dut
	(
		.clk(clk),
		.reset(reset),
		.inputs(inputs),
		.nodeOut(nodeOut)
	);

	neuronChecker #(.PIPE_DEPTH(PIPE_DEPTH)) u_checker
	(
		.clk(clk),
		.reset(reset),
		.nodeOut(nodeOut),
		.expValid(expValid),
		.expValue(expValue),
		.testId(testId),
		.checkedCount(checkedCount),
		.errorCount(errorCount)
	);

	// ReLU, clamp once bit 13 or above is set, round half up at bit 5
	function automatic logic [`ACT_WIDTH-1:0] quantizeSum(input int sum);
		int scaled;
		scaled = sum >>> `FRAC_BITS;
		if (sum < 0)
		begin
			return '0;
		end
		else if (sum >= (1 << (`FRAC_BITS + `ACT_WIDTH - 1)))
		begin
			return `OUT_MAX;
		end
		return scaled + ((sum >>> (`FRAC_BITS - 1)) & 1);
	endfunction

	task automatic loadTests();
		for (int i = 0; i < MAX_TESTS * ROW_LEN; i++)
		begin
			testMem[i] = {1'b1, i[7:0] ^ i[15:8]};
		end
		$readmemh(TEST_FILE, testMem);
		numTests = 0;
		loadFailed = 1'b0;
		for (int t = 0; t < MAX_TESTS; t++)
		begin
			if (testMem[t * ROW_LEN][8])
			begin
				break;
			end
			if (testMem[t * ROW_LEN + ROW_LEN - 1][8])
			begin
				$display("test %0d in %s has fewer than %0d values", t, TEST_FILE, ROW_LEN);
				loadFailed = 1'b1;
			end
			numTests++;
		end
		if (numTests == 0)
		begin
			$display("no test could be read from %s", TEST_FILE);
			loadFailed = 1'b1;
		end
	endtask

	task automatic buildSchedule();
		schedule.delete();
		numIdle = 0;
		for (int t = 0; t < numTests; t++)
		begin
			if (($random(seed) & 3) == 0)
			begin
				schedule.push_back(-1);
				numIdle++;
			end
			schedule.push_back(t);
		end
		if (numIdle == 0)
		begin
			schedule.push_back(-1);
			numIdle++;
		end
	endtask

	task automatic driveSlot(input int idx);
		activationVec_t vec;
		int base;
		vec = '0;
		if (idx < 0)
		begin
			expValue = quantizeSum(`NODE_BIAS); // zero vector leaves the bias alone
		end
		else
		begin
			base = idx * ROW_LEN;
			for (int k = 0; k < `NODE_INPUTS; k++)
			begin
				vec.act[k] = testMem[base + k][7:0];
			end
			expValue = testMem[base + `NODE_INPUTS][7:0];
		end
		inputs = vec;
		expValid = 1'b1;
		testId = idx;
	endtask

	initial
	begin
		reset = 1'b1;
		inputs = '0;
		expValid = 1'b0;
		expValue = '0;
		testId = -1;
		loadTests();
		if (loadFailed)
		begin
			$display("TESTS FAILED");
			$finish;
		end
		else
		begin
			buildSchedule();
			scheduleReady = 1'b1;
			repeat (RESET_CYCLES) @(posedge clk);
			#DRIVE_DELAY;
			reset = 1'b0;
			foreach (schedule[s])
			begin
				driveSlot(schedule[s]);
				@(posedge clk);
				#DRIVE_DELAY;
			end
			inputs = '0;
			expValid = 1'b0;
			testId = -1;
			wait (checkedCount == schedule.size());
			@(posedge clk);
			$display("%0d slots checked (%0d tests, %0d idle), %0d errors",
				checkedCount, numTests, numIdle, errorCount);
			if (errorCount == 0)
			begin
				$display("TESTS PASSED");
			end
			else
			begin
				$display("TESTS FAILED");
			end
			$finish;
		end
	end

	initial
	begin : watchdog
		int limitCycles;
		wait (scheduleReady);
		limitCycles = schedule.size() + RESET_CYCLES + PIPE_DEPTH + 20;
		#(limitCycles * CLK_PERIOD);
		$display("run timed out after %0d clock cycles", limitCycles);
		$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: node_tests.dat
// one test per line: act[0] to act[74] as signed hex bytes, in groups of five
// the last value on each line is the expected nodeOut
00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  08
01 01 01 01 01  01 01 01 01 01  01 01 01 01 01  01 01 01 01 01  01 01 01 01 01  01 01 01 01 01  01 01 01 01 01  01 01 01 01 01  01 01 01 01 01  01 01 01 01 01  01 01 01 01 01  01 01 01 01 01  01 01 01 01 01  01 01 01 01 01  01 01 01 01 01  07
ff ff ff ff ff  ff ff ff ff ff  ff ff ff ff ff  ff ff ff ff ff  ff ff ff ff ff  ff ff ff ff ff  ff ff ff ff ff  ff ff ff ff ff  ff ff ff ff ff  ff ff ff ff ff  ff ff ff ff ff  ff ff ff ff ff  ff ff ff ff ff  ff ff ff ff ff  ff ff ff ff ff  09
40 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  1b
10 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 20 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 f0 00 00 00  00 00 00 00 00  00 00 00 00 05  20
7f 00 7f 7f 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  3b 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  80
7f 00 7f 7f 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  3a 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  7f
7f 00 7f 7f 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  7f 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  7f
00 00 00 00 00  00 00 00 00 00  00 00 00 80 80  80 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  7f
80 80 80 80 80  80 80 80 80 80  80 80 80 80 80  80 80 80 80 80  80 80 80 80 80  80 80 80 80 80  80 80 80 80 80  80 80 80 80 80  80 80 80 80 80  80 80 80 80 80  80 80 80 80 80  80 80 80 80 80  80 80 80 80 80  80 80 80 80 80  80 80 80 80 80  7f
80 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00
7f 7f 7f 7f 7f  7f 7f 7f 7f 7f  7f 7f 7f 7f 7f  7f 7f 7f 7f 7f  7f 7f 7f 7f 7f  7f 7f 7f 7f 7f  7f 7f 7f 7f 7f  7f 7f 7f 7f 7f  7f 7f 7f 7f 7f  7f 7f 7f 7f 7f  7f 7f 7f 7f 7f  7f 7f 7f 7f 7f  7f 7f 7f 7f 7f  7f 7f 7f 7f 7f  7f 7f 7f 7f 7f  00
00 00 00 00 15  00 03 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00
00 04 00 00 15  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00
00 00 00 00 14  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  01
00 00 00 00 14  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 ff 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00 00 00 00 00  00

// File: build.f
+incdir+.
node_pkg.sv
nodeInputCapture.sv
weightedSum.sv
reluQuantize.sv
neuronNode.sv
neuronChecker.sv
neuronNode_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the neuron testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module neuronNode_tb -f build.f -o simNode
buildStatus=$?
if [ $buildStatus -ne 0 ]; then
	echo "verilator build failed with status $buildStatus"
	exit 1
fi

simOut=$(./obj_dir/simNode)
simStatus=$?
echo "$simOut"
if [ $simStatus -ne 0 ]; then
	echo "simulation exited with status $simStatus"
	exit 1
fi

if echo "$simOut" | grep -q "^TESTS PASSED$"; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1
